//--- test/vec_cases.txt
# mem_op mode opcode sew vta vma vm vl vmask rs1 imm vs2 vs1 vd expected, all hex
# Registers are written with the highest element first, element 0 in the low digits
0 0 00 0 0 0 1 10 0000 0 00 ffffffffffffffffffffffffffffffff 01010101010101010101010101010101 0 00000000000000000000000000000000
0 0 00 1 0 0 1 08 0000 0 00 80008000800080008000800080008000 80018001800180018001800180018001 0 00010001000100010001000100010001
0 0 00 2 0 0 1 04 0000 0 00 ffffffff000000017fffffff12345678 00000001ffffffff0000000111111111 0 00000000000000008000000023456789
0 0 00 3 0 0 1 02 0000 0 00 ffffffffffffffff0000000000000005 00000000000000020000000000000003 0 00000000000000010000000000000008
0 0 01 0 0 0 1 10 0000 0 00 00112233445566778899aabbccddeeff 01010101010101010101010101010101 0 ff102132435465768798a9bacbdcedfe
0 0 01 2 0 0 1 04 0000 0 00 00000000000000108000000000000005 00000001000000010000000100000005 0 ffffffff0000000f7fffffff00000000
0 0 03 1 0 0 1 08 0000 0 00 ff00ff00ff00ff00ff00ff00ff00ff00 0ff00ff00ff00ff00ff00ff00ff00ff0 0 0f000f000f000f000f000f000f000f00
0 0 04 3 0 0 1 02 0000 0 00 f0f0f0f0f0f0f0f00000000000000000 0f0f0f0f0f0f0f0f1234567890abcdef 0 ffffffffffffffff1234567890abcdef
0 0 05 0 0 0 1 10 0000 0 00 ffffffffffffffff0000000000000000 0123456789abcdef0123456789abcdef 0 fedcba98765432100123456789abcdef
0 1 02 2 0 0 1 04 0000 abcdef0000000064 00 0000000100000064000000c8ffffffff 0 0 0000006300000000ffffff9c00000065
0 2 02 0 0 0 1 10 0000 0 1f 000102030405060708090a0b0c0d0e0f 0 0 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0
0 1 06 1 0 0 1 08 0000 13 00 00010002100020018000ffff01234567 0 0 00080010800000080000fff809182b38
0 2 07 2 0 0 1 04 0000 0 04 80000000ffffffff123456780000000f 0 0 080000000fffffff0123456700000000
0 1 08 3 0 0 1 02 0000 ffffffffffffff04 00 800000000000000000000000000000f0 0 0 f800000000000000000000000000000f
0 2 08 0 0 0 1 10 0000 0 0b 807ff010ff01c040807ff010ff01c040 0 0 f00ffe02ff00f808f00ffe02ff00f808
0 1 09 0 0 0 1 10 0000 80 00 007f8081ff01fe7e007f8081ff01fe7e 0 0 007f80808001807e007f80808001807e
0 1 0a 0 0 0 1 10 0000 01 00 007f8081ff01fe7e007f8081ff01fe7e 0 0 00018081ff01fe0100018081ff01fe01
0 2 0b 1 0 0 1 08 0000 0 10 00007fff8000fff0fff1ffff1234ffef 0 0 fff0fff0fff0fff0fff1fffffff0fff0
0 2 0c 1 0 0 1 08 0000 0 10 00007fff8000fff0fff1ffff1234ffef 0 0 00007ffffff0fff0fff1ffff1234fff0
0 1 13 2 0 0 1 04 0000 00000000deadbeef 00 0123456789abcdef0123456789abcdef 0 0 deadbeefdeadbeefdeadbeefdeadbeef
0 2 13 3 0 0 1 02 0000 0 15 0123456789abcdef0123456789abcdef 0 0 fffffffffffffff5fffffffffffffff5
0 0 0d 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 01000000010000000101000001000100
0 0 0e 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 00010101000101010000010100010001
0 0 0f 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 00010000000101010000010100010001
0 0 10 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 00000101000101010000000000010001
0 0 11 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 00000101000000000000000000000000
0 0 12 0 0 0 1 10 0000 0 00 007f80ff1010800105fe7f00aa55c3c3 00807f7f1011ff0205fe80ffaa56c3c4 0 00010000000000000000010100000000
0 0 0d 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000003 0 00000000000000000000000000000001
0 0 0e 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000003 0 00000000000000010000000000000000
0 0 0f 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000007 0 00000000000000000000000000000001
0 0 10 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000007 0 00000000000000010000000000000001
0 0 11 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000007 0 00000000000000010000000000000000
0 0 12 3 0 0 1 02 0000 0 00 80000000000000000000000000000003 00000000000000010000000000000001 0 00000000000000000000000000000001
0 0 00 1 0 0 0 05 ff15 0 00 10071006100510041003100210011000 01000100010001000100010001000100 d007d006d005d004d003d002d001d000 d007d006d0051104d0031102d0011100
0 0 00 1 0 1 0 05 ff15 0 00 10071006100510041003100210011000 01000100010001000100010001000100 d007d006d005d004d003d002d001d000 d007d006d0051104ffff1102ffff1100
0 0 00 1 1 0 0 05 ff15 0 00 10071006100510041003100210011000 01000100010001000100010001000100 d007d006d005d004d003d002d001d000 ffffffffffff1104d0031102d0011100
0 0 00 1 1 1 0 05 ff15 0 00 10071006100510041003100210011000 01000100010001000100010001000100 d007d006d005d004d003d002d001d000 ffffffffffff1104ffff1102ffff1100
0 1 13 0 1 0 1 00 0000 5a 00 0 0 0123456789abcdef0123456789abcdef ffffffffffffffffffffffffffffffff
2 0 00 0 0 0 1 10 0000 0000000000000030 00 0 0 0123456789abcdeffedcba9876543210 0
2 0 00 0 0 0 1 10 0000 ffff0000000001a5 00 0 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0
1 0 00 3 0 0 1 02 0000 0000000000000030 00 0 0 0 0123456789abcdeffedcba9876543210
1 0 00 2 1 0 0 03 0005 00000000000000a0 00 0 0 11111111222222223333333344444444 ffffffff5a5a5a5a33333333f0f0f0f0

//--- src.f
hw/vec_pkg.sv
hw/vec_simd_alu.sv
hw/vec_mask_tail.sv
hw/vec_mem.sv
hw/vec_ctrl.sv
hw/vec_unit.sv
test/tb_clk_gen.sv
test/tb_vec_unit.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_vec_unit -o tb_vec_unit
	@out=$$(./obj_dir/tb_vec_unit); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- test/tb_vec_unit.sv
`timescale 1ns/1ps

module tb_vec_unit import vec_pkg::*; ();

    localparam int    CLK_NS      = 20;
    localparam int    NFIELDS     = 15;
    localparam int    HOLD_CASE   = 33;
    localparam int    HOLD_CYCLES = 5;
    localparam string CASE_FILE   = "test/vec_cases.txt";

    logic              clk;
    logic              rst;
    logic              req;
    logic              ack;
    mem_op_t           mem_op;
    valu_mode_t        mode;
    valu_op_t          opcode;
    sew_t              sew;
    logic              vta;
    logic              vma;
    logic              vm;
    logic [VL_W-1:0]   vl;
    logic [VLEN/8-1:0] vmask;
    logic [ELEN-1:0]   rs1;
    logic [4:0]        imm;
    logic [VLEN-1:0]   vs1;
    logic [VLEN-1:0]   vs2;
    logic [VLEN-1:0]   vd;
    logic [VLEN-1:0]   vd_out;

    // Flat list of fields with NFIELDS per case
    logic [VLEN-1:0]   fields [$];
    int                num_cases;
    bit                loaded;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    vec_unit dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .mem_op (mem_op),
        .mode   (mode),
        .opcode (opcode),
        .sew    (sew),
        .vta    (vta),
        .vma    (vma),
        .vm     (vm),
        .vl     (vl),
        .vmask  (vmask),
        .rs1    (rs1),
        .imm    (imm),
        .vs1    (vs1),
        .vs2    (vs2),
        .vd     (vd),
        .vd_out (vd_out)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string what, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_idle();
        req    = 1'b0;
        mem_op = OP_ALU;
        mode   = VV_OP;
        opcode = VADD;
        sew    = SEW_8;
        vta    = 1'b0;
        vma    = 1'b0;
        vm     = 1'b1;
        vl     = '0;
        vmask  = '0;
        rs1    = '0;
        imm    = '0;
        vs1    = '0;
        vs2    = '0;
        vd     = '0;
    endtask

    task automatic load_cases();
        int              fd;
        int              cnt;
        string           line;
        logic [VLEN-1:0] f [NFIELDS];
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing case file");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                          f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (cnt != NFIELDS) begin
                $display("Malformed line in the case file: %s", line);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bad case file");
            end
            for (int k = 0; k < NFIELDS; k++) begin
                fields.push_back(f[k]);
            end
        end
        $fclose(fd);
        num_cases = fields.size() / NFIELDS;
        if (num_cases == 0) begin
            $display("The case file holds no cases");
            $display("TEST RESULT: FAIL");
            $fatal(1, "empty case file");
        end
    endtask

    // One full four-phase transfer with inputs changed on falling edges only
    task automatic run_case(input int n);
        int              base;
        int              edges;
        logic [VLEN-1:0] expected;
        base     = n * NFIELDS;
        expected = fields[base + 14];
        @(negedge clk);
        mem_op = mem_op_t'(fields[base][1:0]);
        mode   = valu_mode_t'(fields[base + 1][1:0]);
        opcode = valu_op_t'(fields[base + 2][4:0]);
        sew    = sew_t'(fields[base + 3][1:0]);
        vta    = fields[base + 4][0];
        vma    = fields[base + 5][0];
        vm     = fields[base + 6][0];
        vl     = fields[base + 7][VL_W-1:0];
        vmask  = fields[base + 8][VLEN/8-1:0];
        rs1    = fields[base + 9][ELEN-1:0];
        imm    = fields[base + 10][4:0];
        vs2    = fields[base + 11];
        vs1    = fields[base + 12];
        vd     = fields[base + 13];
        req    = 1'b1;

        // Rising edges from req high until ack is seen
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!ack);
        check_value($sformatf("case %0d ack latency", n), VLEN'(edges), VLEN'(2));
        check_value($sformatf("case %0d vd_out", n), vd_out, expected);

        if (n == HOLD_CASE) begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_value("ack while req held", VLEN'(ack), VLEN'(1));
                check_value("vd_out while req held", vd_out, expected);
            end
        end

        req   = 1'b0;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack);
        check_value($sformatf("case %0d ack release", n), VLEN'(edges), VLEN'(1));
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        drive_idle();
        load_cases();
        loaded = 1'b1;
        @(negedge rst);
        @(negedge clk);
        check_value("ack after reset", VLEN'(ack), '0);
        check_value("vd_out after reset", vd_out, '0);
        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Budget of 10 periods per case plus 20 for reset and slack
    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(num_cases) * 10 + 20) * CLK_NS;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the req/ack handshake hung", limit_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD_NS = 20;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset covers the first two clock periods
    initial begin
        rst = 1'b1;
        #(2 * PERIOD_NS);
        rst = 1'b0;
    end

endmodule

//--- hw/vec_unit.sv
`timescale 1ns/1ps

module vec_unit import vec_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    output logic               ack,
    input  mem_op_t            mem_op,
    input  valu_mode_t         mode,
    input  valu_op_t           opcode,
    input  sew_t               sew,
    input  logic               vta,
    input  logic               vma,
    input  logic               vm,
    input  logic [VL_W-1:0]    vl,
    input  logic [VLEN/8-1:0]  vmask,
    input  logic [ELEN-1:0]    rs1,
    input  logic [4:0]         imm,
    input  logic [VLEN-1:0]    vs1,
    input  logic [VLEN-1:0]    vs2,
    input  logic [VLEN-1:0]    vd,
    output logic [VLEN-1:0]    vd_out
);

    // Captured instruction
    valu_mode_t            c_mode;
    valu_op_t              c_opcode;
    sew_t                  c_sew;
    logic                  c_vta;
    logic                  c_vma;
    logic                  c_vm;
    logic [VL_W-1:0]       c_vl;
    logic [VLEN/8-1:0]     c_vmask;
    logic [ELEN-1:0]       c_rs1;
    logic [4:0]            c_imm;
    vreg_t                 c_vs1;
    vreg_t                 c_vs2;
    vreg_t                 c_vd;

    // Datapath
    vreg_t                 alu_res;
    vreg_t                 pre_mask;
    vreg_t                 masked;
    vreg_t                 vd_q;
    logic [VLEN-1:0]       rd_data;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic                  wr_en;

    assign vd_out = vd_q;

    vec_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .mem_op   (mem_op),
        .mode     (mode),
        .opcode   (opcode),
        .sew      (sew),
        .vta      (vta),
        .vma      (vma),
        .vm       (vm),
        .vl       (vl),
        .vmask    (vmask),
        .rs1      (rs1),
        .imm      (imm),
        .vs1      (vs1),
        .vs2      (vs2),
        .vd       (vd),
        .alu_res  (alu_res),
        .rd_data  (rd_data),
        .masked   (masked),
        .ack      (ack),
        .c_mode   (c_mode),
        .c_opcode (c_opcode),
        .c_sew    (c_sew),
        .c_vta    (c_vta),
        .c_vma    (c_vma),
        .c_vm     (c_vm),
        .c_vl     (c_vl),
        .c_vmask  (c_vmask),
        .c_rs1    (c_rs1),
        .c_imm    (c_imm),
        .c_vs1    (c_vs1),
        .c_vs2    (c_vs2),
        .c_vd     (c_vd),
        .mem_addr (mem_addr),
        .wr_en    (wr_en),
        .pre_mask (pre_mask),
        .vd_out   (vd_q)
    );

    vec_simd_alu u_alu (
        .opcode  (c_opcode),
        .mode    (c_mode),
        .sew     (c_sew),
        .vs2     (c_vs2),
        .vs1     (c_vs1),
        .rs1     (c_rs1),
        .imm     (c_imm),
        .alu_res (alu_res)
    );

    vec_mask_tail u_mask_tail (
        .sew     (c_sew),
        .vl      (c_vl),
        .vm      (c_vm),
        .vmask   (c_vmask),
        .vta     (c_vta),
        .vma     (c_vma),
        .new_val (pre_mask),
        .old_val (c_vd),
        .res     (masked)
    );

    // Store data is the old destination value
    vec_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .addr    (mem_addr),
        .wr_en   (wr_en),
        .wr_data (c_vd),
        .rd_data (rd_data)
    );

endmodule

//--- hw/vec_ctrl.sv
`timescale 1ns/1ps

module vec_ctrl import vec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  mem_op_t               mem_op,
    input  valu_mode_t            mode,
    input  valu_op_t              opcode,
    input  sew_t                  sew,
    input  logic                  vta,
    input  logic                  vma,
    input  logic                  vm,
    input  logic [VL_W-1:0]       vl,
    input  logic [VLEN/8-1:0]     vmask,
    input  logic [ELEN-1:0]       rs1,
    input  logic [4:0]            imm,
    input  vreg_t                 vs1,
    input  vreg_t                 vs2,
    input  vreg_t                 vd,
    input  vreg_t                 alu_res,
    input  logic [VLEN-1:0]       rd_data,
    input  vreg_t                 masked,
    output logic                  ack,
    output valu_mode_t            c_mode,
    output valu_op_t              c_opcode,
    output sew_t                  c_sew,
    output logic                  c_vta,
    output logic                  c_vma,
    output logic                  c_vm,
    output logic [VL_W-1:0]       c_vl,
    output logic [VLEN/8-1:0]     c_vmask,
    output logic [ELEN-1:0]       c_rs1,
    output logic [4:0]            c_imm,
    output vreg_t                 c_vs1,
    output vreg_t                 c_vs2,
    output vreg_t                 c_vd,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic                  wr_en,
    output vreg_t                 pre_mask,
    output vreg_t                 vd_out
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1,
        DONE = 2'd2
    } state_t;

    state_t  state;
    mem_op_t c_mem_op;
    logic    accept;

    assign accept = (state == IDLE) && req && !ack;

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            ack    <= 1'b0;
            vd_out <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (c_mem_op == OP_STORE) begin
                        vd_out <= '0;
                    end else begin
                        vd_out <= masked;
                    end
                    ack   <= 1'b1;
                    state <= DONE;
                end
                DONE: begin
                    // Hold result until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (accept) begin
            c_mem_op <= mem_op;
            c_mode   <= mode;
            c_opcode <= opcode;
            c_sew    <= sew;
            c_vta    <= vta;
            c_vma    <= vma;
            c_vm     <= vm;
            c_vl     <= vl;
            c_vmask  <= vmask;
            c_rs1    <= rs1;
            c_imm    <= imm;
            c_vs1    <= vs1;
            c_vs2    <= vs2;
            c_vd     <= vd;
        end
    end

    // Store commits on the edge that raises ack
    assign wr_en    = (state == EXEC) && (c_mem_op == OP_STORE);
    assign mem_addr = c_rs1[ADDR_LSB +: MEM_ADDR_W];

    always_comb begin
        if (c_mem_op == OP_LOAD) begin
            pre_mask = rd_data;
        end else begin
            pre_mask = alu_res;
        end
    end

endmodule

//--- hw/vec_mem.sv
`timescale 1ns/1ps

module vec_mem import vec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [MEM_ADDR_W-1:0] addr,
    input  logic                  wr_en,
    input  logic [VLEN-1:0]       wr_data,
    output logic [VLEN-1:0]       rd_data
);

    logic [VLEN-1:0] mem [MEM_WORDS];

    // Whole-word write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Read is combinational from the captured address
    assign rd_data = mem[addr];

endmodule

//--- hw/vec_mask_tail.sv
`timescale 1ns/1ps

module vec_mask_tail import vec_pkg::*; (
    input  sew_t               sew,
    input  logic [VL_W-1:0]    vl,
    input  logic               vm,
    input  logic [VLEN/8-1:0]  vmask,
    input  logic               vta,
    input  logic               vma,
    input  vreg_t              new_val,
    input  vreg_t              old_val,
    output vreg_t              res
);

    // Element index that owns each byte at the current SEW
    logic [3:0] idx;

    // Decided per byte. Every byte of one element shares the same
    // index, so the whole element follows one rule
    always_comb begin
        res = '0;
        idx = '0;
        for (int j = 0; j < VLEN/8; j++) begin
            idx = 4'(j >> sew);
            if (5'(idx) >= vl) begin
                // Tail
                if (vta) begin
                    res.b[j] = 8'hff;
                end else begin
                    res.b[j] = old_val.b[j];
                end
            end else if (!vm && !vmask[idx]) begin
                // Masked off body element
                if (vma) begin
                    res.b[j] = 8'hff;
                end else begin
                    res.b[j] = old_val.b[j];
                end
            end else begin
                res.b[j] = new_val.b[j];
            end
        end
    end

endmodule

//--- hw/vec_simd_alu.sv
`timescale 1ns/1ps

module vec_simd_alu import vec_pkg::*; (
    input  valu_op_t         opcode,
    input  valu_mode_t       mode,
    input  sew_t             sew,
    input  vreg_t            vs2,
    input  vreg_t            vs1,
    input  logic [ELEN-1:0]  rs1,
    input  logic [4:0]       imm,
    output vreg_t            alu_res
);

    logic [ELEN-1:0] imm_ext;
    logic [ELEN-1:0] scalar;
    vreg_t           b_vec;
    logic [ELEN-1:0] elem_r;

    // Operands arrive sign-extended to ELEN, which keeps both signed and
    // unsigned ordering intact. Only srl needs the zero-extended form.
    function automatic logic [ELEN-1:0] elem_op(
        input valu_op_t        op,
        input sew_t            s,
        input logic [ELEN-1:0] a,
        input logic [ELEN-1:0] b
    );
        logic [ELEN-1:0] a_zx;
        logic [5:0]      sh;
        logic [ELEN-1:0] r;
        case (s)
            SEW_8: begin
                a_zx = {56'b0, a[7:0]};
                sh   = {3'b0, b[2:0]};
            end
            SEW_16: begin
                a_zx = {48'b0, a[15:0]};
                sh   = {2'b0, b[3:0]};
            end
            SEW_32: begin
                a_zx = {32'b0, a[31:0]};
                sh   = {1'b0, b[4:0]};
            end
            default: begin
                a_zx = a;
                sh   = b[5:0];
            end
        endcase
        case (op)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VRSUB:   r = b - a;
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VSLL:    r = a << sh;
            VSRL:    r = a_zx >> sh;
            VSRA:    r = $signed(a) >>> sh;
            VMINU:   r = (a < b) ? a : b;
            VMIN:    r = ($signed(a) < $signed(b)) ? a : b;
            VMAXU:   r = (a > b) ? a : b;
            VMAX:    r = ($signed(a) > $signed(b)) ? a : b;
            VMSEQ:   r = ELEN'(a == b);
            VMSNE:   r = ELEN'(a != b);
            VMSLTU:  r = ELEN'(a < b);
            VMSLT:   r = ELEN'($signed(a) < $signed(b));
            VMSGTU:  r = ELEN'(a > b);
            VMSGT:   r = ELEN'($signed(a) > $signed(b));
            VMV:     r = b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // ------------------------------
    // Operand b
    // ------------------------------
    assign imm_ext = {{(ELEN-5){imm[4]}}, imm};
    assign scalar  = (mode == VX_OP) ? rs1 : imm_ext;

    always_comb begin
        if (mode == VV_OP) begin
            b_vec = vs1;
        end else begin
            case (sew)
                SEW_8:   b_vec.b = {(VLEN/8){scalar[7:0]}};
                SEW_16:  b_vec.h = {(VLEN/16){scalar[15:0]}};
                SEW_32:  b_vec.w = {(VLEN/32){scalar[31:0]}};
                default: b_vec.d = {(VLEN/64){scalar}};
            endcase
        end
    end

    // ------------------------------
    // Lanes
    // ------------------------------
    always_comb begin
        alu_res = '0;
        elem_r  = '0;
        case (sew)
            SEW_8: begin
                for (int i = 0; i < VLEN/8; i++) begin
                    elem_r = elem_op(opcode, sew,
                                     {{56{vs2.b[i][7]}}, vs2.b[i]},
                                     {{56{b_vec.b[i][7]}}, b_vec.b[i]});
                    alu_res.b[i] = elem_r[7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < VLEN/16; i++) begin
                    elem_r = elem_op(opcode, sew,
                                     {{48{vs2.h[i][15]}}, vs2.h[i]},
                                     {{48{b_vec.h[i][15]}}, b_vec.h[i]});
                    alu_res.h[i] = elem_r[15:0];
                end
            end
            SEW_32: begin
                for (int i = 0; i < VLEN/32; i++) begin
                    elem_r = elem_op(opcode, sew,
                                     {{32{vs2.w[i][31]}}, vs2.w[i]},
                                     {{32{b_vec.w[i][31]}}, b_vec.w[i]});
                    alu_res.w[i] = elem_r[31:0];
                end
            end
            default: begin
                for (int i = 0; i < VLEN/64; i++) begin
                    elem_r = elem_op(opcode, sew, vs2.d[i], b_vec.d[i]);
                    alu_res.d[i] = elem_r;
                end
            end
        endcase
    end

endmodule

//--- hw/vec_pkg.sv
package vec_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int VLEN       = 128;
    localparam int ELEN       = 64;
    localparam int VL_W       = 5;
    localparam int MEM_WORDS  = 16;
    localparam int MEM_ADDR_W = 4;
    // 16 bytes per memory word
    localparam int ADDR_LSB   = 4;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [1:0] {
        VV_OP = 2'd0,
        VX_OP = 2'd1,
        VI_OP = 2'd2
    } valu_mode_t;

    // a is the vs2 element, b the operand-b element
    typedef enum logic [4:0] {
        VADD   = 5'd0,
        VSUB   = 5'd1,
        VRSUB  = 5'd2,
        VAND   = 5'd3,
        VOR    = 5'd4,
        VXOR   = 5'd5,
        VSLL   = 5'd6,
        VSRL   = 5'd7,
        VSRA   = 5'd8,
        VMINU  = 5'd9,
        VMIN   = 5'd10,
        VMAXU  = 5'd11,
        VMAX   = 5'd12,
        VMSEQ  = 5'd13,
        VMSNE  = 5'd14,
        VMSLTU = 5'd15,
        VMSLT  = 5'd16,
        VMSGTU = 5'd17,
        VMSGT  = 5'd18,
        VMV    = 5'd19
    } valu_op_t;

    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_t;

    // One register whose element view is picked by SEW
    typedef union packed {
        logic [VLEN/8-1:0][7:0]   b;
        logic [VLEN/16-1:0][15:0] h;
        logic [VLEN/32-1:0][31:0] w;
        logic [VLEN/64-1:0][63:0] d;
    } vreg_t;

endpackage
